/* compile.f */
src/sdr_pkg.sv
src/sdr_link_rx.sv
src/sdr_fifo.sv
src/sdr_link_tx.sv
src/sdr_link_stage.sv
testbench/tb_sdr_link_stage.sv

/* Makefile */
VERILATOR  ?= verilator
SIM_FLAGS  ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing --assert
TOP        ?= tb_sdr_link_stage
FILELIST   ?= compile.f
OBJ_DIR    ?= obj_dir
PASS_MSG   := Simulation completed successfully

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o $(TOP)

run: build
	@out="$$(./$(OBJ_DIR)/$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

/* testbench/tb_sdr_link_stage.sv */
module tb_sdr_link_stage;

  import sdr_pkg::*;

  localparam int ORDER_PACKETS   = 40;
  localparam int LATENCY_PACKETS = TOKEN_CREDITS;
  localparam int LIMIT_PACKETS   = 2 * FIFO_DEPTH;
  localparam int RECOVER_PACKETS = 12;
  localparam int TOTAL_PACKETS   =
    ORDER_PACKETS + LATENCY_PACKETS + LIMIT_PACKETS + RECOVER_PACKETS;
  localparam int TIMEOUT_CYCLES  = TOTAL_PACKETS * 20 + 200;

  // downstream token behavior
  localparam int DOWN_WITHHOLD = 0;
  localparam int DOWN_PROMPT   = 1;
  localparam int DOWN_RANDOM   = 2;

  logic    ext_clk_i = 1'b0;
  logic    rst_n_i = 1'b0;
  logic    io_fwd_v_i = 1'b0;
  packet_t io_fwd_data_i = '0;
  logic    io_fwd_token_i = 1'b0;
  logic    io_fwd_token_o;
  logic    io_fwd_v_o;
  packet_t io_fwd_data_o;

  // upstream and downstream models
  logic [31:0] lfsr = 32'h268d_a038;
  int   up_credit = FIFO_DEPTH;
  int   send_idx = 0;
  int   send_target = 0;
  logic up_random = 1'b0;
  int   down_mode = DOWN_PROMPT;
  int   tok_given = 0;
  int   grant_req = 0;
  int   grant_done = 0;
  int   token_count = 0;
  logic send_now;
  logic grant_now;

  // monitor bookkeeping
  int in_count = 0;
  int out_count = 0;
  int cyc = 0;
  int in_cyc [TOTAL_PACKETS];
  int out_cyc [TOTAL_PACKETS];
  int mon_errs = 0;

  string cur_test = "reset";
  int    ctl_errs = 0;
  int    errs_at_start = 0;
  int    pass_count = 0;
  int    fail_count = 0;
  int    base;
  int    n;

  sdr_link_stage dut_i (
    .ext_clk_i       (ext_clk_i)
    ,.rst_n_i        (rst_n_i)
    ,.io_fwd_v_i     (io_fwd_v_i)
    ,.io_fwd_data_i  (io_fwd_data_i)
    ,.io_fwd_token_o (io_fwd_token_o)
    ,.io_fwd_v_o     (io_fwd_v_o)
    ,.io_fwd_data_o  (io_fwd_data_o)
    ,.io_fwd_token_i (io_fwd_token_i)
  );

  always #50 ext_clk_i = ~ext_clk_i;

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return (s >> 1) ^ (s[0] ? 32'h8020_0003 : 32'h0);
  endfunction

  // expected packet for a given sequence number
  function automatic packet_t ref_packet(input int index);
    packet_t p;
    p.op     = packet_op_e'(index % 4);
    p.addr   = 16'(index * 37 + 'h1200);
    p.data   = 32'(index * 32'h0101_0101) ^ 32'hc3a5_0f5a;
    p.x_cord = 4'(index);
    p.y_cord = 4'(index / 4) ^ 4'h9;
    return p;
  endfunction

  task automatic report_mismatch(input string what, input logic [63:0] exp,
                                 input logic [63:0] act);
    $display("[ERROR] %s: %s expected %0h actual %0h", cur_test, what, exp, act);
  endtask

  task automatic report_problem(input string msg);
    $display("[ERROR] %s: %s", cur_test, msg);
  endtask

  task automatic start_test(input string name);
    cur_test = name;
    errs_at_start = mon_errs + ctl_errs;
  endtask

  task automatic finish_test();
    int errs;
    errs = mon_errs + ctl_errs - errs_at_start;
    if (errs == 0) begin
      pass_count++;
      $display("test %s: ok", cur_test);
    end else begin
      fail_count++;
      $display("test %s: FAILED with %0d errors", cur_test, errs);
    end
  endtask

  task automatic idle(input int cycles);
    repeat (cycles) @(negedge ext_clk_i);
  endtask

  task automatic wait_out(input int target, input int limit);
    int k;
    k = 0;
    while (out_count < target && k < limit) begin
      @(negedge ext_clk_i);
      k++;
    end
    if (out_count < target) begin
      report_problem($sformatf("only %0d of %0d packets left the stage in time",
                               out_count, target));
      ctl_errs++;
    end
  endtask

  // one token pulse per group of dequeued packets
  task automatic check_tokens();
    @(posedge ext_clk_i);
    if (token_count != out_count / TOKEN_CREDITS) begin
      report_mismatch("token pulses", 64'(out_count / TOKEN_CREDITS), 64'(token_count));
      ctl_errs++;
    end
  endtask

  // upstream sender and downstream receiver, driven on the falling edge
  always @(negedge ext_clk_i) begin
    if (rst_n_i) begin
      if (io_fwd_token_o) begin
        up_credit = up_credit + TOKEN_CREDITS;
        token_count++;
      end
      send_now = 1'b0;
      if (send_idx < send_target && up_credit > 0) begin
        if (up_random) begin
          lfsr = lfsr_next(lfsr);
          send_now = lfsr[0];
        end else begin
          send_now = 1'b1;
        end
      end
      io_fwd_v_i = send_now;
      if (send_now) begin
        io_fwd_data_i = ref_packet(send_idx);
        send_idx++;
        up_credit--;
      end
      // downstream frees a whole group before it returns a token
      grant_now = 1'b0;
      if (out_count - TOKEN_CREDITS * tok_given >= TOKEN_CREDITS) begin
        case (down_mode)
          DOWN_PROMPT: grant_now = 1'b1;
          DOWN_RANDOM: begin
            lfsr = lfsr_next(lfsr);
            grant_now = lfsr[0];
          end
          default: begin
            if (grant_done < grant_req) begin
              grant_now = 1'b1;
              grant_done++;
            end
          end
        endcase
      end
      if (grant_now) begin
        tok_given++;
      end
      io_fwd_token_i = grant_now;
    end
  end

  // compare process
  always @(posedge ext_clk_i) begin
    cyc++;
    if (rst_n_i) begin
      if (up_credit > FIFO_DEPTH) begin
        report_problem("upstream credit grew above the buffer depth");
        mon_errs++;
      end
      if (io_fwd_v_i && in_count < TOTAL_PACKETS) begin
        in_cyc[in_count] = cyc;
        in_count++;
      end
      if (io_fwd_v_o) begin
        if (out_count >= TOTAL_PACKETS) begin
          report_problem("more packets left the stage than were sent");
          mon_errs++;
        end else begin
          if (io_fwd_data_o !== ref_packet(out_count)) begin
            report_mismatch($sformatf("packet %0d", out_count),
                            64'(ref_packet(out_count)), 64'(io_fwd_data_o));
            mon_errs++;
          end
          out_cyc[out_count] = cyc;
          out_count++;
        end
      end
    end
  end

  initial begin
    repeat (TIMEOUT_CYCLES) @(posedge ext_clk_i);
    $display("timeout: the stage did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("Simulation failed");
    $finish;
  end

  initial begin
    repeat (3) @(posedge ext_clk_i);
    @(negedge ext_clk_i);
    rst_n_i = 1'b1;

    start_test("reset");
    repeat (2) begin
      @(posedge ext_clk_i);
      if (io_fwd_v_o !== 1'b0 || io_fwd_token_o !== 1'b0) begin
        report_mismatch("v and token", 64'(0), 64'({io_fwd_v_o, io_fwd_token_o}));
        ctl_errs++;
      end
    end
    finish_test();

    start_test("order");
    @(posedge ext_clk_i);
    up_random = 1'b1;
    send_target = ORDER_PACKETS;
    wait_out(ORDER_PACKETS, ORDER_PACKETS * 20);
    idle(8);
    if (out_count != ORDER_PACKETS) begin
      report_mismatch("packets out", 64'(ORDER_PACKETS), 64'(out_count));
      ctl_errs++;
    end
    check_tokens();
    finish_test();

    // first packet enters an idle stage, the rest complete its token group
    start_test("latency");
    @(posedge ext_clk_i);
    up_random = 1'b0;
    base = send_target;
    send_target = base + LATENCY_PACKETS;
    wait_out(send_target, 50);
    idle(8);
    if (out_cyc[base] - in_cyc[base] != 2) begin
      report_mismatch("latency", 64'(2), 64'(out_cyc[base] - in_cyc[base]));
      ctl_errs++;
    end
    check_tokens();
    finish_test();

    start_test("credit limit");
    @(posedge ext_clk_i);
    down_mode = DOWN_WITHHOLD;
    base = out_count;
    send_target = send_target + LIMIT_PACKETS;
    wait_out(base + FIFO_DEPTH, 100);
    repeat (20) begin
      @(negedge ext_clk_i);
      if (io_fwd_v_o !== 1'b0) begin
        report_problem("packet left the stage without downstream credit");
        ctl_errs++;
      end
    end
    @(posedge ext_clk_i);
    grant_req++;
    wait_out(base + FIFO_DEPTH + TOKEN_CREDITS, 50);
    idle(10);
    if (out_count != base + FIFO_DEPTH + TOKEN_CREDITS) begin
      report_mismatch("packets out", 64'(base + FIFO_DEPTH + TOKEN_CREDITS), 64'(out_count));
      ctl_errs++;
    end
    check_tokens();
    finish_test();

    start_test("recovery");
    @(posedge ext_clk_i);
    up_random = 1'b1;
    send_target = send_target + RECOVER_PACKETS;
    n = 0;
    while (in_count - out_count < FIFO_DEPTH && n < 200) begin
      @(negedge ext_clk_i);
      n++;
    end
    idle(10);
    if (in_count - out_count != FIFO_DEPTH) begin
      report_mismatch("packets held", 64'(FIFO_DEPTH), 64'(in_count - out_count));
      ctl_errs++;
    end
    @(posedge ext_clk_i);
    down_mode = DOWN_RANDOM;
    wait_out(send_target, RECOVER_PACKETS * 40);
    idle(8);
    if (out_count != send_target) begin
      report_mismatch("packets out", 64'(send_target), 64'(out_count));
      ctl_errs++;
    end
    check_tokens();
    finish_test();

    start_test("token return");
    if (in_count != TOTAL_PACKETS) begin
      report_mismatch("packets in", 64'(TOTAL_PACKETS), 64'(in_count));
      ctl_errs++;
    end
    check_tokens();
    finish_test();

    $display("tests passed: %0d, tests failed: %0d", pass_count, fail_count);
    if (fail_count == 0 && mon_errs + ctl_errs == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

/* src/sdr_link_stage.sv */
module sdr_link_stage (
  input                     ext_clk_i
  , input                   rst_n_i

  // from the remote side
  , input                   io_fwd_v_i
  , input  sdr_pkg::packet_t io_fwd_data_i
  , output logic            io_fwd_token_o

  // to the next stage
  , output logic            io_fwd_v_o
  , output sdr_pkg::packet_t io_fwd_data_o
  , input                   io_fwd_token_i
);

  import sdr_pkg::*;

  logic    enq_lo;
  packet_t enq_data_lo;
  logic    deq_lo;
  logic    empty_lo;
  logic    full_lo;
  packet_t head_lo;

  sdr_link_rx rx (
    .core_clk_i      (ext_clk_i)
    ,.rst_n_i        (rst_n_i)
    ,.io_fwd_v_i     (io_fwd_v_i)
    ,.io_fwd_data_i  (io_fwd_data_i)
    ,.deq_i          (deq_lo)
    ,.full_i         (full_lo)
    ,.enq_o          (enq_lo)
    ,.enq_data_o     (enq_data_lo)
    ,.io_fwd_token_o (io_fwd_token_o)
  );

  sdr_fifo fifo (
    .core_clk_i  (ext_clk_i)
    ,.rst_n_i    (rst_n_i)
    ,.enq_i      (enq_lo)
    ,.enq_data_i (enq_data_lo)
    ,.deq_i      (deq_lo)
    ,.empty_o    (empty_lo)
    ,.full_o     (full_lo)
    ,.head_o     (head_lo)
  );

  sdr_link_tx tx (
    .core_clk_i      (ext_clk_i)
    ,.rst_n_i        (rst_n_i)
    ,.empty_i        (empty_lo)
    ,.head_i         (head_lo)
    ,.deq_o          (deq_lo)
    ,.io_fwd_token_i (io_fwd_token_i)
    ,.io_fwd_v_o     (io_fwd_v_o)
    ,.io_fwd_data_o  (io_fwd_data_o)
  );

endmodule

/* src/sdr_link_tx.sv */
module sdr_link_tx (
  input                     core_clk_i
  , input                   rst_n_i

  // buffer side
  , input                   empty_i
  , input  sdr_pkg::packet_t head_i
  , output logic            deq_o

  // outgoing link
  , input                   io_fwd_token_i
  , output logic            io_fwd_v_o
  , output sdr_pkg::packet_t io_fwd_data_o
);

  import sdr_pkg::*;

  logic [CREDIT_WIDTH-1:0] credit_r;
  logic [CREDIT_WIDTH-1:0] credit_n;
  logic                    has_credit;
  logic                    launch;

  logic                    v_r;
  packet_t                 data_r;

  assign has_credit = (credit_r != '0);

  // take the head as soon as there is something to send and room downstream
  assign launch = !empty_i && has_credit;
  assign deq_o  = launch;

  // spend one credit per launch, a token adds a whole group back
  always_comb begin
    credit_n = credit_r;
    if (launch) begin
      credit_n = credit_n - 1'b1;
    end
    if (io_fwd_token_i) begin
      credit_n = credit_n + CREDIT_WIDTH'(TOKEN_CREDITS);
    end
  end

  // downstream is another stage of the same depth
  always_ff @(posedge core_clk_i) begin
    if (!rst_n_i) begin
      credit_r <= CREDIT_WIDTH'(FIFO_DEPTH);
    end else begin
      credit_r <= credit_n;
    end
  end

  always_ff @(posedge core_clk_i) begin
    if (!rst_n_i) begin
      v_r <= 1'b0;
    end else begin
      v_r <= launch;
    end
  end

  // payload only moves when a packet goes out
  always_ff @(posedge core_clk_i) begin
    if (launch) begin
      data_r <= head_i;
    end
  end

  assign io_fwd_v_o    = v_r;
  assign io_fwd_data_o = data_r;

  // tokens never return more than was sent
  a_credit_bound: assert property (
    @(posedge core_clk_i) disable iff (!rst_n_i)
    credit_r <= CREDIT_WIDTH'(FIFO_DEPTH)
  ) else $error("sdr_link_tx: credit count above downstream depth");

endmodule

/* src/sdr_fifo.sv */
module sdr_fifo (
  input                     core_clk_i
  , input                   rst_n_i

  // write side
  , input                   enq_i
  , input  sdr_pkg::packet_t enq_data_i

  // read side
  , input                   deq_i
  , output logic            empty_o
  , output logic            full_o
  , output sdr_pkg::packet_t head_o
);

  import sdr_pkg::*;

  packet_t mem [FIFO_DEPTH];

  // extra msb tells full from empty
  logic [LG_FIFO_DEPTH:0] wr_ptr_r;
  logic [LG_FIFO_DEPTH:0] rd_ptr_r;
  logic [LG_FIFO_DEPTH:0] count;

  logic [LG_FIFO_DEPTH-1:0] wr_idx;
  logic [LG_FIFO_DEPTH-1:0] rd_idx;

  assign wr_idx = wr_ptr_r[LG_FIFO_DEPTH-1:0];
  assign rd_idx = rd_ptr_r[LG_FIFO_DEPTH-1:0];

  // occupancy wraps cleanly with the wide pointers
  assign count   = wr_ptr_r - rd_ptr_r;
  assign empty_o = (count == '0);
  assign full_o  = (count == (LG_FIFO_DEPTH+1)'(FIFO_DEPTH));

  // storage
  always_ff @(posedge core_clk_i) begin
    if (enq_i) begin
      mem[wr_idx] <= enq_data_i;
    end
  end

  // pointers
  always_ff @(posedge core_clk_i) begin
    if (!rst_n_i) begin
      wr_ptr_r <= '0;
      rd_ptr_r <= '0;
    end else begin
      if (enq_i) begin
        wr_ptr_r <= wr_ptr_r + 1'b1;
      end
      if (deq_i) begin
        rd_ptr_r <= rd_ptr_r + 1'b1;
      end
    end
  end

  // head is valid whenever not empty
  assign head_o = mem[rd_idx];

  a_no_underflow: assert property (
    @(posedge core_clk_i) disable iff (!rst_n_i)
    deq_i |-> !empty_o
  ) else $error("sdr_fifo: dequeue while empty");

  // a full buffer may only be written when a slot frees in the same cycle
  a_no_overflow: assert property (
    @(posedge core_clk_i) disable iff (!rst_n_i)
    (enq_i && full_o) |-> deq_i
  ) else $error("sdr_fifo: enqueue while full");

endmodule

/* src/sdr_link_rx.sv */
module sdr_link_rx (
  input                     core_clk_i
  , input                   rst_n_i

  // remote side
  , input                   io_fwd_v_i
  , input  sdr_pkg::packet_t io_fwd_data_i

  // buffer side
  , input                   deq_i
  , input                   full_i
  , output logic            enq_o
  , output sdr_pkg::packet_t enq_data_o

  // credit return to the remote sender
  , output logic            io_fwd_token_o
);

  import sdr_pkg::*;

  logic [LG_CREDIT_TO_TOKEN_DECIMATION-1:0] deq_cnt_r;
  logic                                     token_r;
  logic                                     group_done;

  // incoming packets go straight into the buffer
  assign enq_o      = io_fwd_v_i;
  assign enq_data_o = io_fwd_data_i;

  // last freed slot of a decimation group
  assign group_done = deq_i && (deq_cnt_r == '1);

  always_ff @(posedge core_clk_i) begin
    if (!rst_n_i) begin
      deq_cnt_r <= '0;
      token_r   <= 1'b0;
    end else begin
      if (deq_i) begin
        deq_cnt_r <= deq_cnt_r + 1'b1;
      end
      token_r <= group_done;
    end
  end

  assign io_fwd_token_o = token_r;

  // remote credit is bounded by free slots, so a full buffer never sees valid
  a_no_overflow: assert property (
    @(posedge core_clk_i) disable iff (!rst_n_i)
    io_fwd_v_i |-> !full_i
  ) else $error("sdr_link_rx: packet arrived while buffer full");

  // opcode must be one of the defined encodings
  a_known_op: assert property (
    @(posedge core_clk_i) disable iff (!rst_n_i)
    io_fwd_v_i |-> (io_fwd_data_i.op inside {e_op_load, e_op_store,
                                             e_op_remote_store_mask, e_op_amo})
  ) else $error("sdr_link_rx: unknown opcode on valid packet");

endmodule

/* src/sdr_pkg.sv */
package sdr_pkg;

  // packet field widths
  localparam int ADDR_WIDTH   = 16;
  localparam int DATA_WIDTH   = 32;
  localparam int X_CORD_WIDTH = 4;
  localparam int Y_CORD_WIDTH = 4;
  localparam int OP_WIDTH     = 2;

  localparam int PACKET_WIDTH =
    OP_WIDTH + ADDR_WIDTH + DATA_WIDTH + X_CORD_WIDTH + Y_CORD_WIDTH;

  // link buffer sizing
  localparam int LG_FIFO_DEPTH = 3;
  localparam int FIFO_DEPTH    = 1 << LG_FIFO_DEPTH;

  // one token pulse is worth this many credits
  localparam int LG_CREDIT_TO_TOKEN_DECIMATION = 2;
  localparam int TOKEN_CREDITS = 1 << LG_CREDIT_TO_TOKEN_DECIMATION;

  // counter must reach FIFO_DEPTH itself
  localparam int CREDIT_WIDTH = LG_FIFO_DEPTH + 1;

  // forward opcodes
  typedef enum logic [OP_WIDTH-1:0] {
    e_op_load              = 2'd0,
    e_op_store             = 2'd1,
    e_op_remote_store_mask = 2'd2,
    e_op_amo               = 2'd3
  } packet_op_e;

  // forward packet, op in the top bits
  typedef struct packed {
    packet_op_e                op;
    logic [ADDR_WIDTH-1:0]     addr;
    logic [DATA_WIDTH-1:0]     data;
    logic [X_CORD_WIDTH-1:0]   x_cord;
    logic [Y_CORD_WIDTH-1:0]   y_cord;
  } packet_t;

endpackage
